// File: logic/pad_pkg.sv
// Controller types shared by the adapter decode, allocation and packing stages
// Stick values are two's complement once the adapter bias is removed
// Bit n of every pad_bus_t button vector belongs to player n+1

package pad_pkg;

	// ========================================================================
	// Adapter report as delivered by the serial front end
	// ========================================================================

	typedef struct packed {
		logic [31:0] buttons;
		logic [71:0] analog;
		logic [7:0]  dev_type;
		logic        enabled;
	} llapi_raw_t;

	localparam logic [7:0] LLAPI_STICK_BIAS  = 8'd128;
	localparam logic [7:0] LLAPI_TYPE_NONE   = 8'd0;
	localparam logic [7:0] LLAPI_TYPE_SEARCH = 8'd255;

	// Adapter button indices, HID id minus one
	localparam int LLAPI_BTN_B       = 0;
	localparam int LLAPI_BTN_A       = 1;
	localparam int LLAPI_BTN_C_LEFT  = 2;
	localparam int LLAPI_BTN_C_DOWN  = 3;
	localparam int LLAPI_BTN_Z       = 4;
	localparam int LLAPI_BTN_START   = 5;
	localparam int LLAPI_BTN_L       = 6;
	localparam int LLAPI_BTN_R       = 7;
	localparam int LLAPI_BTN_C_UP    = 8;
	localparam int LLAPI_BTN_C_RIGHT = 9;
	localparam int LLAPI_BTN_RIGHT   = 24;
	localparam int LLAPI_BTN_LEFT    = 25;
	localparam int LLAPI_BTN_DOWN    = 26;
	localparam int LLAPI_BTN_UP      = 27;

	// ========================================================================
	// Player-side types
	// ========================================================================

	// Same bit order as the low 14 bits of the USB joystick word
	typedef struct packed {
		logic c_left;
		logic c_down;
		logic c_right;
		logic c_up;
		logic z;
		logic r;
		logic l;
		logic start;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_btn_t;

	typedef struct packed {
		pad_btn_t          btn;
		logic signed [7:0] stick_x;
		logic signed [7:0] stick_y;
	} pad_state_t;

	// Bits 14 to 19 carry host extras and are not used
	typedef logic [19:0] usb_joy_t;

	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} usb_stick_t;

	typedef struct packed {
		logic [3:0]      right;
		logic [3:0]      left;
		logic [3:0]      down;
		logic [3:0]      up;
		logic [3:0]      a;
		logic [3:0]      b;
		logic [3:0]      start;
		logic [3:0]      l;
		logic [3:0]      r;
		logic [3:0]      z;
		logic [3:0]      c_up;
		logic [3:0]      c_right;
		logic [3:0]      c_down;
		logic [3:0]      c_left;
		logic [3:0][7:0] stick_x;
		logic [3:0][7:0] stick_y;
	} pad_bus_t;

endpackage

// File: logic/cfg_pkg.sv
// Configuration register map and display-geometry constants
// Offsets are byte addresses, so the APB address needs at least 3 bits
// Aspect pairs never use the scaled-size flag in bit 12

package cfg_pkg;

	localparam logic [7:0] CFG_PAD_ADDR   = 8'h0;
	localparam logic [7:0] CFG_VIDEO_ADDR = 8'h4;

	// Bit 0 routes P1 C-right to P2 Z, bit 1 to P3 Z
	typedef struct packed {
		logic dual_p3;
		logic dual_p2;
	} pad_cfg_t;

	// Register bits 6 down to 0 in field order
	typedef struct packed {
		logic       pal;
		logic [1:0] crop;
		logic [1:0] ar_mode;
		logic       blanks_off;
		logic       direct_fb;
	} video_cfg_t;

	localparam logic [1:0] CROP_NONE        = 2'd0;
	localparam logic [1:0] CROP_8           = 2'd1;
	localparam logic [1:0] CROP_12          = 2'd2;
	localparam logic [1:0] AR_MODE_ORIGINAL = 2'd0;

	typedef struct packed {
		logic [12:0] arx;
		logic [12:0] ary;
	} aspect_t;

	// ========================================================================
	// Aspect table, x:y per TV standard and crop
	// ========================================================================

	localparam aspect_t AR_NTSC_NONE   = '{arx: 13'd512,  ary: 13'd381};
	localparam aspect_t AR_NTSC_CROP8  = '{arx: 13'd1280, ary: 13'd889};
	localparam aspect_t AR_NTSC_CROP12 = '{arx: 13'd2560, ary: 13'd1714};
	localparam aspect_t AR_PAL_NONE    = '{arx: 13'd512,  ary: 13'd387};
	localparam aspect_t AR_PAL_CROP8   = '{arx: 13'd1024, ary: 13'd731};
	localparam aspect_t AR_PAL_CROP12  = '{arx: 13'd2048, ary: 13'd1419};
	localparam aspect_t AR_FALLBACK    = '{arx: 13'd4,    ary: 13'd3};

endpackage

// File: logic/apb_cfg_regs.sv
// APB slave with zero wait states, pready is tied high
// Unmapped offsets raise pslverr, writes to them are dropped and reads give zero
// APB_ADDR_WIDTH must be at least 3 to reach the video register

module apb_cfg_regs #(
	parameter int APB_ADDR_WIDTH = 4
) (
	input  logic                      clk_1x,
	input  logic                      RESET,
	input  logic [APB_ADDR_WIDTH-1:0] paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	output cfg_pkg::pad_cfg_t         pad_cfg,
	output cfg_pkg::video_cfg_t       video_cfg
);
	import cfg_pkg::*;

	logic access;
	logic sel_pad;
	logic sel_video;

	assign access    = psel && penable;
	assign sel_pad   = paddr == APB_ADDR_WIDTH'(CFG_PAD_ADDR);
	assign sel_video = paddr == APB_ADDR_WIDTH'(CFG_VIDEO_ADDR);

	assign pready  = 1'b1;
	assign pslverr = access && !sel_pad && !sel_video;

	// Read mux, zero for anything unmapped
	always_comb begin
		if (sel_pad)
			prdata = 32'(pad_cfg);
		else if (sel_video)
			prdata = 32'(video_cfg);
		else
			prdata = '0;
	end

	// Write lands on the edge that closes the access phase
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pad_cfg   <= '0;
			video_cfg <= '0;
		end else if (access && pwrite) begin
			if (sel_pad)
				pad_cfg <= pad_cfg_t'(pwdata[$bits(pad_cfg_t)-1:0]);
			if (sel_video)
				video_cfg <= video_cfg_t'(pwdata[$bits(video_cfg_t)-1:0]);
		end
	end

	a_penable_in_psel: assert property (@(posedge clk_1x) disable iff (!RESET)
		penable |-> psel);

	// Setup must be followed by access at the same address
	a_addr_stable: assert property (@(posedge clk_1x) disable iff (!RESET)
		(psel && !penable) |=> (psel && penable && $stable(paddr)));

endmodule

// File: logic/llapi_pad_decode.sv
// Combinational decode of one adapter port report
// Only analog bytes 0 and 1 (left stick) are used
// menu_combo ignores the validity check on purpose

module llapi_pad_decode (
	input  pad_pkg::llapi_raw_t raw,
	output pad_pkg::pad_state_t pad,
	output logic                valid,
	output logic                menu_combo
);
	import pad_pkg::*;

	always_comb begin
		pad.btn.right   = raw.buttons[LLAPI_BTN_RIGHT];
		pad.btn.left    = raw.buttons[LLAPI_BTN_LEFT];
		pad.btn.down    = raw.buttons[LLAPI_BTN_DOWN];
		pad.btn.up      = raw.buttons[LLAPI_BTN_UP];
		pad.btn.a       = raw.buttons[LLAPI_BTN_A];
		pad.btn.b       = raw.buttons[LLAPI_BTN_B];
		pad.btn.start   = raw.buttons[LLAPI_BTN_START];
		pad.btn.l       = raw.buttons[LLAPI_BTN_L];
		pad.btn.r       = raw.buttons[LLAPI_BTN_R];
		pad.btn.z       = raw.buttons[LLAPI_BTN_Z];
		pad.btn.c_up    = raw.buttons[LLAPI_BTN_C_UP];
		pad.btn.c_right = raw.buttons[LLAPI_BTN_C_RIGHT];
		pad.btn.c_down  = raw.buttons[LLAPI_BTN_C_DOWN];
		pad.btn.c_left  = raw.buttons[LLAPI_BTN_C_LEFT];
		// Raw sticks rest at 0x80
		pad.stick_x = signed'(raw.analog[7:0] - LLAPI_STICK_BIAS);
		pad.stick_y = signed'(raw.analog[15:8] - LLAPI_STICK_BIAS);
	end

	// Type 0 is no pad (or Atari), 255 means the adapter is still searching
	assign valid = raw.enabled && (raw.dev_type != LLAPI_TYPE_NONE)
		&& (raw.dev_type != LLAPI_TYPE_SEARCH);

	// Down + Start + B opens the on-screen menu
	assign menu_combo = raw.buttons[LLAPI_BTN_DOWN] && raw.buttons[LLAPI_BTN_START]
		&& raw.buttons[LLAPI_BTN_B];

endmodule

// File: logic/player_allocator.sv
// Combinational player allocation, index 0 is player 1
// Adapters take the first slots unless only port 2 holds a pad
// Invalid adapters still occupy slots 1 and 2 in the normal order

module player_allocator (
	input  pad_pkg::pad_state_t       ll_pad_1,
	input  pad_pkg::pad_state_t       ll_pad_2,
	input  logic                      ll_valid_1,
	input  logic                      ll_valid_2,
	input  pad_pkg::usb_joy_t   [2:0] usb_joy,
	input  pad_pkg::usb_stick_t [2:0] usb_stick,
	output pad_pkg::pad_state_t [3:0] players
);
	import pad_pkg::*;

	pad_state_t [2:0] usb_pad;

	// Host word already has the player button order in its low bits
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			usb_pad[i].btn     = pad_btn_t'(usb_joy[i][$bits(pad_btn_t)-1:0]);
			usb_pad[i].stick_x = usb_stick[i].x;
			usb_pad[i].stick_y = usb_stick[i].y;
		end
	end

	always_comb begin
		if (!ll_valid_1 && ll_valid_2) begin
			players[0] = ll_pad_2;
			players[1] = usb_pad[0];
			players[2] = usb_pad[1];
			players[3] = usb_pad[2];
		end else begin
			players[0] = ll_pad_1;
			players[1] = ll_pad_2;
			players[2] = usb_pad[0];
			players[3] = usb_pad[1];
		end
	end

endmodule

// File: logic/pad_bus_packer.sv
// Registers the four players as per-button vectors, one cycle latency
// Dual-controller mode overrides the Z bit of player 2 and/or player 3
// Player 4 Z is never rerouted

module pad_bus_packer (
	input  logic                      clk_1x,
	input  logic                      RESET,
	input  pad_pkg::pad_state_t [3:0] players,
	input  cfg_pkg::pad_cfg_t         pad_cfg,
	input  logic                      menu_combo_1,
	input  logic                      menu_combo_2,
	output pad_pkg::pad_bus_t         pad_bus,
	output logic                      osd_request
);
	import pad_pkg::*;

	pad_bus_t bus_next;

	// Transpose players into button vectors
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			bus_next.right[i]   = players[i].btn.right;
			bus_next.left[i]    = players[i].btn.left;
			bus_next.down[i]    = players[i].btn.down;
			bus_next.up[i]      = players[i].btn.up;
			bus_next.a[i]       = players[i].btn.a;
			bus_next.b[i]       = players[i].btn.b;
			bus_next.start[i]   = players[i].btn.start;
			bus_next.l[i]       = players[i].btn.l;
			bus_next.r[i]       = players[i].btn.r;
			bus_next.z[i]       = players[i].btn.z;
			bus_next.c_up[i]    = players[i].btn.c_up;
			bus_next.c_right[i] = players[i].btn.c_right;
			bus_next.c_down[i]  = players[i].btn.c_down;
			bus_next.c_left[i]  = players[i].btn.c_left;
			bus_next.stick_x[i] = players[i].stick_x;
			bus_next.stick_y[i] = players[i].stick_y;
		end
		// P1 C-right doubles as Z for the second controller
		if (pad_cfg.dual_p2)
			bus_next.z[1] = players[0].btn.c_right;
		if (pad_cfg.dual_p3)
			bus_next.z[2] = players[0].btn.c_right;
	end

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pad_bus     <= '0;
			osd_request <= 1'b0;
		end else begin
			pad_bus     <= bus_next;
			osd_request <= menu_combo_1 || menu_combo_2;
		end
	end

endmodule

// File: logic/aspect_ratio_sel.sv
// Aspect-ratio pair registered one cycle after the video settings change
// Non-zero ar_mode passes ar_mode-1 with ary zero as a scaler preset
// Reserved crop value keeps whatever pair was selected before

module aspect_ratio_sel (
	input  logic                clk_1x,
	input  logic                RESET,
	input  cfg_pkg::video_cfg_t video_cfg,
	output cfg_pkg::aspect_t    aspect
);
	import cfg_pkg::*;

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			aspect <= AR_FALLBACK;
		end else if (video_cfg.ar_mode != AR_MODE_ORIGINAL) begin
			aspect.arx <= {11'd0, video_cfg.ar_mode - 2'd1};
			aspect.ary <= '0;
		end else if (video_cfg.blanks_off || video_cfg.direct_fb) begin
			// Without fixed blanks the table does not apply
			aspect <= AR_FALLBACK;
		end else begin
			case (video_cfg.crop)
				CROP_NONE: aspect <= video_cfg.pal ? AR_PAL_NONE : AR_NTSC_NONE;
				CROP_8:    aspect <= video_cfg.pal ? AR_PAL_CROP8 : AR_NTSC_CROP8;
				CROP_12:   aspect <= video_cfg.pal ? AR_PAL_CROP12 : AR_NTSC_CROP12;
				default:   aspect <= aspect;
			endcase
		end
	end

endmodule

// File: logic/pad_hub_top.sv
// Controller input and display geometry block of the console wrapper
// Pad inputs reach pad_bus and osd_request after exactly one clock
// Adapter words arrive already decoded from the serial protocol

module pad_hub_top #(
	parameter int APB_ADDR_WIDTH = 4
) (
	input  logic                      clk_1x,
	input  logic                      RESET,
	input  logic [APB_ADDR_WIDTH-1:0] paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  pad_pkg::llapi_raw_t       llapi_raw_1,
	input  pad_pkg::llapi_raw_t       llapi_raw_2,
	input  pad_pkg::usb_joy_t   [2:0] usb_joy,
	input  pad_pkg::usb_stick_t [2:0] usb_stick,
	output pad_pkg::pad_bus_t         pad_bus,
	output logic                      osd_request,
	output cfg_pkg::aspect_t          aspect
);
	import pad_pkg::*;
	import cfg_pkg::*;

	pad_cfg_t         pad_cfg;
	video_cfg_t       video_cfg;
	pad_state_t       ll_pad_1;
	pad_state_t       ll_pad_2;
	logic             ll_valid_1;
	logic             ll_valid_2;
	logic             menu_combo_1;
	logic             menu_combo_2;
	pad_state_t [3:0] players;

	// ========================================================================
	// Input side
	// ========================================================================

	apb_cfg_regs #(
		.APB_ADDR_WIDTH(APB_ADDR_WIDTH)
	) u_cfg_regs (
		.clk_1x   (clk_1x),
		.RESET    (RESET),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.pad_cfg  (pad_cfg),
		.video_cfg(video_cfg)
	);

	llapi_pad_decode u_llapi_1 (
		.raw       (llapi_raw_1),
		.pad       (ll_pad_1),
		.valid     (ll_valid_1),
		.menu_combo(menu_combo_1)
	);

	llapi_pad_decode u_llapi_2 (
		.raw       (llapi_raw_2),
		.pad       (ll_pad_2),
		.valid     (ll_valid_2),
		.menu_combo(menu_combo_2)
	);

	// ========================================================================
	// Processing
	// ========================================================================

	player_allocator u_alloc (
		.ll_pad_1  (ll_pad_1),
		.ll_pad_2  (ll_pad_2),
		.ll_valid_1(ll_valid_1),
		.ll_valid_2(ll_valid_2),
		.usb_joy   (usb_joy),
		.usb_stick (usb_stick),
		.players   (players)
	);

	// ========================================================================
	// Output side
	// ========================================================================

	pad_bus_packer u_packer (
		.clk_1x      (clk_1x),
		.RESET       (RESET),
		.players     (players),
		.pad_cfg     (pad_cfg),
		.menu_combo_1(menu_combo_1),
		.menu_combo_2(menu_combo_2),
		.pad_bus     (pad_bus),
		.osd_request (osd_request)
	);

	aspect_ratio_sel u_aspect (
		.clk_1x   (clk_1x),
		.RESET    (RESET),
		.video_cfg(video_cfg),
		.aspect   (aspect)
	);

endmodule

// File: dv/pad_hub_tb.sv
// Runs the operations of dv/pad_hub_input.txt, relative to the project root
// Pad results are checked one clock after the inputs change
// Aspect results one clock after the video write, outputs sampled on the falling edge

module pad_hub_tb;
	import pad_pkg::*;
	import cfg_pkg::*;

	localparam int    RESET_CYCLES = 16;
	localparam string VEC_FILE     = "dv/pad_hub_input.txt";

	logic             clk_1x = 1'b0;
	logic             RESET;
	logic [3:0]       paddr;
	logic             psel;
	logic             penable;
	logic             pwrite;
	logic [31:0]      pwdata;
	logic [31:0]      prdata;
	logic             pready;
	logic             pslverr;
	llapi_raw_t       llapi_raw_1;
	llapi_raw_t       llapi_raw_2;
	usb_joy_t   [2:0] usb_joy;
	usb_stick_t [2:0] usb_stick;
	pad_bus_t         pad_bus;
	logic             osd_request;
	aspect_t          aspect;

	// Staged pad inputs, applied together by the next P line
	llapi_raw_t       raw_next_1;
	llapi_raw_t       raw_next_2;
	usb_joy_t   [2:0] joy_next;
	usb_stick_t [2:0] stick_next;

	string lines[$];
	int    cycle_count = 0;
	int    cycle_limit = 0;
	int    pad_errs = 0;
	int    osd_errs = 0;
	int    aspect_errs = 0;
	int    apb_errs = 0;
	int    other_errs = 0;

	pad_hub_top #(.APB_ADDR_WIDTH(4)) DUT (.*);

	always #50 clk_1x = ~clk_1x;

	always @(posedge clk_1x) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the vector run did not complete", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ========================================================================
	// Result checks
	// ========================================================================

	task automatic check_pad_bus(input pad_bus_t exp);
		if (pad_bus !== exp) begin
			pad_errs++;
			$display("Fail %0t pad_bus expected %h got %h", $time, exp, pad_bus);
		end
	endtask

	task automatic check_osd(input logic exp);
		if (osd_request !== exp) begin
			osd_errs++;
			$display("Fail %0t osd_request expected %b got %b", $time, exp, osd_request);
		end
	endtask

	task automatic check_aspect(input aspect_t exp);
		if (aspect !== exp) begin
			aspect_errs++;
			$display("Fail %0t aspect expected %0d:%0d got %0d:%0d", $time,
				exp.arx, exp.ary, aspect.arx, aspect.ary);
		end
	endtask

	task automatic check_apb(input logic [31:0] exp_data, input logic exp_err);
		if (prdata !== exp_data) begin
			apb_errs++;
			$display("Fail %0t prdata expected %h got %h", $time, exp_data, prdata);
		end
		if (pslverr !== exp_err) begin
			apb_errs++;
			$display("Fail %0t pslverr expected %b got %b", $time, exp_err, pslverr);
		end
		if (pready !== 1'b1) begin
			apb_errs++;
			$display("Fail %0t pready expected 1 got %b", $time, pready);
		end
	endtask

	// ========================================================================
	// Bus and pad drivers
	// ========================================================================

	// Setup, access, then idle on the edge where the write lands
	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk_1x);
		paddr   <= addr;
		pwdata  <= data;
		pwrite  <= 1'b1;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk_1x);
		penable <= 1'b1;
		@(posedge clk_1x);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp_data,
		input logic exp_err);
		@(posedge clk_1x);
		paddr   <= addr;
		pwrite  <= 1'b0;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk_1x);
		penable <= 1'b1;
		@(negedge clk_1x);
		check_apb(exp_data, exp_err);
		@(posedge clk_1x);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apply_pads(input pad_bus_t exp_bus, input logic exp_osd);
		@(posedge clk_1x);
		llapi_raw_1 <= raw_next_1;
		llapi_raw_2 <= raw_next_2;
		usb_joy     <= joy_next;
		usb_stick   <= stick_next;
		@(posedge clk_1x);
		@(negedge clk_1x);
		check_pad_bus(exp_bus);
		check_osd(exp_osd);
	endtask

	task automatic set_video(input logic [31:0] data, input aspect_t exp);
		apb_write(4'(CFG_VIDEO_ADDR), data);
		@(posedge clk_1x);
		@(negedge clk_1x);
		check_aspect(exp);
	endtask

	// ========================================================================
	// Vector file handling
	// ========================================================================

	task automatic load_vectors();
		int    fd;
		string line;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			other_errs++;
			$display("Cannot open vector file %s", VEC_FILE);
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.getc(0) != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		if (lines.size() == 0) begin
			other_errs++;
			$display("Vector file %s holds no operations", VEC_FILE);
		end
	endtask

	function automatic int op_cycles(input string line);
		case (line.getc(0))
			"W", "R": return 3;
			"V":      return 4;
			"P":      return 2;
			default:  return 0;
		endcase
	endfunction

	task automatic run_op(input string line);
		byte         op;
		bit          ok;
		logic [31:0] sel;
		logic [31:0] word;
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] kind;
		logic [31:0] flag;
		logic [55:0] btn_vec;
		llapi_raw_t  raw;
		ok = 1'b0;
		case (line.getc(0))
			"W": begin
				ok = ($sscanf(line, "%c %h %h", op, sel, word) == 3);
				if (ok)
					apb_write(sel[3:0], word);
			end
			"R": begin
				ok = ($sscanf(line, "%c %h %h %h", op, sel, word, flag) == 4);
				if (ok)
					apb_read(sel[3:0], word, flag[0]);
			end
			"V": begin
				ok = ($sscanf(line, "%c %h %h %h", op, word, x, y) == 4);
				if (ok)
					set_video(word, '{arx: x[12:0], ary: y[12:0]});
			end
			"U": begin
				ok = ($sscanf(line, "%c %h %h %h", op, sel, word, x) == 4) && sel < 3;
				if (ok) begin
					joy_next[sel[1:0]]   = word[19:0];
					stick_next[sel[1:0]] = usb_stick_t'(x[15:0]);
				end
			end
			"L": begin
				ok = ($sscanf(line, "%c %h %h %h %h %h %h", op, sel, word, x, y, kind, flag)
					== 7) && (sel == 1 || sel == 2);
				// Left stick in analog bytes 0 and 1, the other bytes idle
				raw.buttons  = word;
				raw.analog   = {56'd0, y[7:0], x[7:0]};
				raw.dev_type = kind[7:0];
				raw.enabled  = flag[0];
				if (ok && sel == 1)
					raw_next_1 = raw;
				else if (ok)
					raw_next_2 = raw;
			end
			"P": begin
				ok = ($sscanf(line, "%c %h %h %h %h", op, btn_vec, x, y, flag) == 5);
				if (ok)
					apply_pads(pad_bus_t'({btn_vec, x, y}), flag[0]);
			end
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			other_errs++;
			$display("Malformed line in vector file: %s", line);
		end
	endtask

	initial begin
		int vec_cycles;
		vec_cycles  = 0;
		RESET       = 1'b0;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		llapi_raw_1 = '0;
		llapi_raw_2 = '0;
		usb_joy     = '0;
		usb_stick   = '0;
		raw_next_1  = '0;
		raw_next_2  = '0;
		joy_next    = '0;
		stick_next  = '0;
		load_vectors();
		foreach (lines[i])
			vec_cycles += op_cycles(lines[i]);
		cycle_limit = 4 * vec_cycles + RESET_CYCLES + 8;

		// Reset values, still inside reset
		repeat (RESET_CYCLES - 1) @(posedge clk_1x);
		@(negedge clk_1x);
		check_pad_bus('0);
		check_osd(1'b0);
		check_aspect('{arx: 13'd4, ary: 13'd3});
		@(posedge clk_1x);
		RESET <= 1'b1;

		foreach (lines[i])
			run_op(lines[i]);
		repeat (2) @(posedge clk_1x);

		$display("Errors: pad_bus %0d, osd_request %0d, aspect %0d, apb %0d, other %0d",
			pad_errs, osd_errs, aspect_errs, apb_errs, other_errs);
		if (pad_errs + osd_errs + aspect_errs + apb_errs + other_errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pad_hub_tb -f pad_hub_top.f -o pad_hub_sim

./obj_dir/pad_hub_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// File: pad_hub_top.f
logic/pad_pkg.sv
logic/cfg_pkg.sv
logic/apb_cfg_regs.sv
logic/llapi_pad_decode.sv
logic/player_allocator.sv
logic/pad_bus_packer.sv
logic/aspect_ratio_sel.sv
logic/pad_hub_top.sv
dv/pad_hub_tb.sv

// File: dv/pad_hub_input.txt
# W addr data | R addr data err | V video arx ary | U idx joy stick | L port buttons x y type en
# P button vectors right..c_left, stick_x p4..p1, stick_y p4..p1, osd (L and U stage, P applies)
R 0 00000000 0
R 4 00000000 0
W 0 00000003
R 0 00000003 0
W 4 0000007f
R 4 0000007f 0
W 8 00000055
R 8 00000000 1
R 0 00000003 0
R 4 0000007f 0
W 0 00000000
L 1 090001AA 80 C0 01 1
L 2 00000000 80 80 00 0
U 0 02010 10F0
U 1 00001 0205
U 2 00200 3333
P 90015010101014 05F00000 02100040 0
L 1 06000255 80 C0 01 1
P 81104101010105 05F00000 02100040 0
L 2 00000080 90 70 01 1
L 1 06000255 80 C0 00 1
P 40002000180002 3305F010 330210F0 0
L 1 06000255 80 C0 FF 1
P 40002000180002 3305F010 330210F0 0
L 1 06000255 80 C0 01 1
P 81104101210105 05F01000 0210F040 0
W 0 00000001
P 81104101230105 05F01000 0210F040 0
W 0 00000002
P 81104101250105 05F01000 0210F040 0
W 0 00000003
P 81104101270105 05F01000 0210F040 0
L 2 04000021 90 70 01 1
P 81304321070105 05F01000 0210F040 1
V 00 0200 017D
V 10 0500 0379
V 20 0A00 06B2
V 40 0200 0183
V 50 0400 02DB
V 60 0800 058B
V 30 0800 058B
V 08 0001 0000
V 02 0004 0003
V 01 0004 0003
